// File: src/pifo_pkg.sv
`default_nettype none

package pifo_pkg;

   // ------------------------------
   // Field widths
   // ------------------------------
   localparam int PRIO_W     = 16;
   localparam int META_W     = 16;
   localparam int CNT_W      = 8;   // Entries below a slot, itself included
   localparam int FANOUT     = 4;
   localparam int SLOT_IDX_W = 2;
   localparam int ADDR_W     = 4;
   localparam int LAST_LEVEL = 1;   // Bottom of the two-level tree

   localparam int ENTRY_W = PRIO_W + META_W;
   localparam int SLOT_W  = CNT_W + ENTRY_W;
   localparam int WORD_W  = FANOUT * SLOT_W;

   // ------------------------------
   // Types
   // ------------------------------
   typedef logic [PRIO_W-1:0]     prio_t;
   typedef logic [META_W-1:0]     meta_t;
   typedef logic [ENTRY_W-1:0]    entry_t;     // {meta, prio}
   typedef logic [CNT_W-1:0]      count_t;
   typedef logic [SLOT_W-1:0]     slot_t;      // {count, entry}
   typedef logic [WORD_W-1:0]     word_t;      // Slot 0 in the low bits
   typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
   typedef logic [ADDR_W-1:0]     addr_t;

   // All-ones priority marks a free slot
   localparam prio_t  EMPTY_PRIO  = '1;
   localparam meta_t  EMPTY_META  = '1;
   localparam entry_t EMPTY_ENTRY = {EMPTY_META, EMPTY_PRIO};
   localparam slot_t  EMPTY_SLOT  = {count_t'(0), EMPTY_ENTRY};
   localparam word_t  EMPTY_WORD  = {FANOUT{EMPTY_SLOT}};

   typedef enum logic [1:0] {
      IDLE = 2'b00,
      PUSH = 2'b01,
      POP  = 2'b11,
      WB   = 2'b10   // Write-back after a pop
   } node_state_e;

   // ------------------------------
   // Field access
   // ------------------------------
   function automatic slot_t get_slot(word_t w, slot_idx_t idx);
      return w[idx*SLOT_W +: SLOT_W];
   endfunction

   function automatic count_t slot_count(slot_t s);
      return s[SLOT_W-1 -: CNT_W];
   endfunction

   function automatic entry_t slot_entry(slot_t s);
      return s[ENTRY_W-1:0];
   endfunction

   function automatic prio_t entry_prio(entry_t e);
      return e[PRIO_W-1:0];
   endfunction

endpackage

`default_nettype wire

// File: src/pifo_slot_select.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_slot_select (
   input  pifo_pkg::word_t     i_word,
   output pifo_pkg::slot_idx_t o_min_count_slot,
   output pifo_pkg::slot_idx_t o_min_prio_slot
);
   import pifo_pkg::*;

   count_t cnt  [FANOUT];
   prio_t  prio [FANOUT];

   // Unpack the word into per-slot fields
   always_comb begin
      for (int i = 0; i < FANOUT; i++) begin
         cnt[i]  = slot_count(get_slot(i_word, slot_idx_t'(i)));
         prio[i] = entry_prio(slot_entry(get_slot(i_word, slot_idx_t'(i))));
      end
   end

   // ------------------------------
   // Smallest subtree
   // ------------------------------
   always_comb begin
      slot_idx_t best;

      best = '0;
      for (int i = 1; i < FANOUT; i++) begin
         // Strict compare, lower index wins a tie
         if (cnt[i] < cnt[best]) begin
            best = slot_idx_t'(i);
         end
      end
      o_min_count_slot = best;
   end

   // ------------------------------
   // Smallest priority
   // ------------------------------
   always_comb begin
      slot_idx_t best;

      best = '0;
      for (int i = 1; i < FANOUT; i++) begin
         if (prio[i] < prio[best]) begin   // Free slots are all ones, never picked over a real one
            best = slot_idx_t'(i);
         end
      end
      o_min_prio_slot = best;
   end

endmodule

`default_nettype wire

// File: src/pifo_node.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_node #(
   parameter int NODE_LEVEL = 0
) (
   input  logic             i_clk,
   input  logic             i_arst_n,

   // Parent side
   input  logic             i_push,
   input  pifo_pkg::entry_t i_push_data,
   input  logic             i_pop,
   output pifo_pkg::entry_t o_pop_data,
   input  pifo_pkg::addr_t  i_my_addr,

   // Child side
   output logic             o_child_push,
   output pifo_pkg::entry_t o_child_push_data,
   output logic             o_child_pop,
   output pifo_pkg::addr_t  o_child_addr,
   input  pifo_pkg::entry_t i_child_pop_data,

   // Level RAM
   output logic             o_read,
   output pifo_pkg::addr_t  o_read_addr,
   input  pifo_pkg::word_t  i_read_data,
   output logic             o_write,
   output pifo_pkg::addr_t  o_write_addr,
   output pifo_pkg::word_t  o_write_data
);
   import pifo_pkg::*;

   localparam bit IS_LEAF = (NODE_LEVEL == LAST_LEVEL);

   node_state_e state_q;
   entry_t      push_data_q;
   addr_t       my_addr_q;
   addr_t       cmd_addr;
   logic        accept;

   slot_idx_t   min_cnt_slot;
   slot_idx_t   min_prio_slot;
   slot_idx_t   sel_slot;
   slot_t       cur_slot;
   count_t      sel_cnt;
   entry_t      sel_entry;
   logic        sel_occupied;
   logic        keep_new;

   slot_t       new_slot;
   word_t       wr_word;
   logic        child_push;
   entry_t      child_push_data;
   logic        child_pop;
   entry_t      pop_data;

   pifo_slot_select u_slot_select (
      .i_word           (i_read_data),
      .o_min_count_slot (min_cnt_slot),
      .o_min_prio_slot  (min_prio_slot)
   );

   // ------------------------------
   // Command acceptance and FSM
   // ------------------------------
   // One strobe only, and never in the cycle right after a pop
   assign accept   = (i_push ^ i_pop) && (state_q != POP);
   assign cmd_addr = (NODE_LEVEL == 0) ? addr_t'(0) : i_my_addr;   // Root is always word 0

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q   <= IDLE;
         my_addr_q <= '0;
      end else if (accept) begin
         state_q   <= i_push ? PUSH : POP;
         my_addr_q <= cmd_addr;
      end else if (state_q == POP) begin
         state_q   <= WB;
      end else begin
         state_q   <= IDLE;
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept && i_push) begin
         push_data_q <= i_push_data;
      end
   end

   // ------------------------------
   // Slot update
   // ------------------------------
   // Push fills the lightest subtree and pop drains the smallest priority
   assign sel_slot     = (state_q == PUSH) ? min_cnt_slot : min_prio_slot;
   assign cur_slot     = get_slot(i_read_data, sel_slot);
   assign sel_cnt      = slot_count(cur_slot);
   assign sel_entry    = slot_entry(cur_slot);
   assign sel_occupied = (entry_prio(sel_entry) != EMPTY_PRIO);
   assign keep_new     = (entry_prio(push_data_q) < entry_prio(sel_entry));

   always_comb begin
      new_slot        = cur_slot;
      child_push      = 1'b0;
      child_push_data = EMPTY_ENTRY;
      child_pop       = 1'b0;
      pop_data        = EMPTY_ENTRY;
      case (state_q)
         PUSH: begin
            if (!sel_occupied || IS_LEAF) begin
               new_slot = {count_t'(sel_cnt + 1'b1), push_data_q};
            end else begin
               // Smaller stays here and larger goes one level down
               child_push = 1'b1;
               if (keep_new) begin
                  new_slot        = {count_t'(sel_cnt + 1'b1), push_data_q};
                  child_push_data = sel_entry;
               end else begin
                  new_slot        = {count_t'(sel_cnt + 1'b1), sel_entry};
                  child_push_data = push_data_q;
               end
            end
         end
         POP: begin
            pop_data  = sel_entry;
            child_pop = !IS_LEAF && (sel_cnt > count_t'(1));   // Anything left below
         end
         WB: begin
            if (!IS_LEAF && (sel_cnt > count_t'(1))) begin
               new_slot = {count_t'(sel_cnt - 1'b1), i_child_pop_data};   // Refill from child
            end else begin
               new_slot = EMPTY_SLOT;
            end
         end
         default: ;
      endcase
   end

   always_comb begin
      wr_word = i_read_data;
      wr_word[sel_slot*SLOT_W +: SLOT_W] = new_slot;
   end

   // ------------------------------
   // Outputs
   // ------------------------------
   assign o_read            = accept;
   assign o_read_addr       = cmd_addr;
   assign o_write           = (state_q == PUSH) || (state_q == WB);
   assign o_write_addr      = my_addr_q;
   assign o_write_data      = wr_word;
   assign o_pop_data        = pop_data;
   assign o_child_push      = child_push;
   assign o_child_push_data = child_push_data;
   assign o_child_pop       = child_pop;
   assign o_child_addr      = addr_t'(FANOUT * my_addr_q + sel_slot);

   // Parent must keep the tree balanced so a leaf slot is always free
   if (IS_LEAF) begin : g_leaf_chk
      a_leaf_slot_free : assert property (@(posedge i_clk) disable iff (!i_arst_n)
         (state_q == PUSH) |-> !sel_occupied);
   end

   // A write only follows an accepted push or a pop
   a_no_idle_write : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_write |-> ($past(accept && i_push) || $past(state_q == POP)));

endmodule

`default_nettype wire

// File: src/pifo_level_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_level_ram #(
   parameter int DEPTH = 1
) (
   input  logic            i_clk,
   input  logic            i_arst_n,
   input  logic            i_read,
   input  pifo_pkg::addr_t i_read_addr,
   output pifo_pkg::word_t o_read_data,
   input  logic            i_write,
   input  pifo_pkg::addr_t i_write_addr,
   input  pifo_pkg::word_t i_write_data
);
   import pifo_pkg::*;

   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   word_t mem [DEPTH];
   word_t rd_q;
   logic  collide;

   assign collide = i_write && (i_write_addr == i_read_addr);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= EMPTY_WORD;   // Tree starts empty
         end
         rd_q <= EMPTY_WORD;
      end else begin
         if (i_write) begin
            mem[i_write_addr[IDX_W-1:0]] <= i_write_data;
         end
         // Output holds between reads, the node relies on that in WB
         if (i_read) begin
            rd_q <= collide ? i_write_data : mem[i_read_addr[IDX_W-1:0]];
         end
      end
   end

   assign o_read_data = rd_q;

   // Parent address arithmetic must stay inside this level
   a_addr_in_range : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !((i_read && (i_read_addr >= DEPTH)) || (i_write && (i_write_addr >= DEPTH))));

endmodule

`default_nettype wire

// File: src/pifo_tree_top.sv
`timescale 1ns/1ps
`default_nettype none

module pifo_tree_top (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_push,
   input  pifo_pkg::entry_t i_push_data,
   input  logic             i_pop,
   output pifo_pkg::entry_t o_pop_data
);
   import pifo_pkg::*;

   // Root to leaf
   logic   leaf_push;
   entry_t leaf_push_data;
   logic   leaf_pop;
   addr_t  leaf_addr;
   entry_t leaf_pop_data;

   // Root RAM port
   logic   root_rd;
   addr_t  root_rd_addr;
   word_t  root_rd_data;
   logic   root_wr;
   addr_t  root_wr_addr;
   word_t  root_wr_data;

   // Leaf RAM port
   logic   leaf_rd;
   addr_t  leaf_rd_addr;
   word_t  leaf_rd_data;
   logic   leaf_wr;
   addr_t  leaf_wr_addr;
   word_t  leaf_wr_data;

   // ------------------------------
   // Level 0
   // ------------------------------
   pifo_node #(.NODE_LEVEL(0)) u_root (
      .i_clk             (i_clk),
      .i_arst_n          (i_arst_n),
      .i_push            (i_push),
      .i_push_data       (i_push_data),
      .i_pop             (i_pop),
      .o_pop_data        (o_pop_data),
      .i_my_addr         (),
      .o_child_push      (leaf_push),
      .o_child_push_data (leaf_push_data),
      .o_child_pop       (leaf_pop),
      .o_child_addr      (leaf_addr),
      .i_child_pop_data  (leaf_pop_data),
      .o_read            (root_rd),
      .o_read_addr       (root_rd_addr),
      .i_read_data       (root_rd_data),
      .o_write           (root_wr),
      .o_write_addr      (root_wr_addr),
      .o_write_data      (root_wr_data)
   );

   pifo_level_ram #(.DEPTH(1)) u_root_ram (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_read       (root_rd),
      .i_read_addr  (root_rd_addr),
      .o_read_data  (root_rd_data),
      .i_write      (root_wr),
      .i_write_addr (root_wr_addr),
      .i_write_data (root_wr_data)
   );

   // ------------------------------
   // Level 1, nothing below
   // ------------------------------
   pifo_node #(.NODE_LEVEL(LAST_LEVEL)) u_leaf (
      .i_clk             (i_clk),
      .i_arst_n          (i_arst_n),
      .i_push            (leaf_push),
      .i_push_data       (leaf_push_data),
      .i_pop             (leaf_pop),
      .o_pop_data        (leaf_pop_data),
      .i_my_addr         (leaf_addr),
      .o_child_push      (),
      .o_child_push_data (),
      .o_child_pop       (),
      .o_child_addr      (),
      .i_child_pop_data  (),
      .o_read            (leaf_rd),
      .o_read_addr       (leaf_rd_addr),
      .i_read_data       (leaf_rd_data),
      .o_write           (leaf_wr),
      .o_write_addr      (leaf_wr_addr),
      .o_write_data      (leaf_wr_data)
   );

   pifo_level_ram #(.DEPTH(FANOUT)) u_leaf_ram (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_read       (leaf_rd),
      .i_read_addr  (leaf_rd_addr),
      .o_read_data  (leaf_rd_data),
      .i_write      (leaf_wr),
      .i_write_addr (leaf_wr_addr),
      .i_write_data (leaf_wr_data)
   );

endmodule

`default_nettype wire

// File: verification/tb_pifo_tree.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pifo_tree;
   import pifo_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int CAPACITY        = 20;
   localparam int RANDOM_CMDS     = 600;
   localparam int DIRECTED_CMDS   = 133;
   localparam int TOTAL_CMDS      = RANDOM_CMDS + DIRECTED_CMDS;
   localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 4 + 50;
   localparam logic [31:0] RAND_SEED = 32'h2872_eda6;

   logic   i_clk = 1'b0;
   logic   i_arst_n;
   logic   i_push;
   entry_t i_push_data;
   logic   i_pop;
   entry_t o_pop_data;

   entry_t      model_q [$];        // Entries the DUT should hold
   logic        last_pop_acc = 1'b0;
   logic        cmd_pop_acc  = 1'b0;
   entry_t      cmd_exp      = EMPTY_ENTRY;
   logic        chk_valid    = 1'b0;
   entry_t      chk_exp      = EMPTY_ENTRY;
   logic [15:0] meta_seq     = 16'h0;

   pifo_tree_top UUT (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_push      (i_push),
      .i_push_data (i_push_data),
      .i_pop       (i_pop),
      .o_pop_data  (o_pop_data)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   // ------------------------------
   // Reference model
   // ------------------------------
   // Smallest priority leaves first and an empty queue gives the empty value
   function automatic entry_t ref_pop();
      int     best;
      entry_t e;

      if (model_q.size() == 0) begin
         return EMPTY_ENTRY;
      end
      best = 0;
      for (int i = 1; i < model_q.size(); i++) begin
         if (model_q[i][PRIO_W-1:0] < model_q[best][PRIO_W-1:0]) begin
            best = i;
         end
      end
      e = model_q[best];
      model_q.delete(best);
      return e;
   endfunction

   // Distinct from everything held and never the free marker
   function automatic prio_t fresh_prio();
      prio_t p;
      logic  taken;

      do begin
         p     = prio_t'($urandom);
         taken = (p == '1);
         foreach (model_q[i]) begin
            if (model_q[i][PRIO_W-1:0] == p) begin
               taken = 1'b1;
            end
         end
      end while (taken);
      return p;
   endfunction

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic drive_cycle(input logic push, input entry_t data, input logic pop);
      logic acc;

      @(posedge i_clk);
      #1;
      acc         = (push ^ pop) && !last_pop_acc;   // Acceptance rule of the top level
      i_push      = push;
      i_push_data = data;
      i_pop       = pop;
      cmd_pop_acc = acc && pop;
      cmd_exp     = EMPTY_ENTRY;
      if (acc && push) begin
         model_q.push_back(data);
      end
      if (acc && pop) begin
         cmd_exp = ref_pop();
      end
      last_pop_acc = acc && pop;
   endtask

   task automatic push_one(input prio_t prio);
      drive_cycle(1'b1, {meta_seq, prio}, 1'b0);
      meta_seq++;
   endtask

   task automatic pop_one();
      drive_cycle(1'b0, EMPTY_ENTRY, 1'b1);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, EMPTY_ENTRY, 1'b0);
   endtask

   // ------------------------------
   // Checker
   // ------------------------------
   always @(posedge i_clk) begin
      chk_valid <= cmd_pop_acc;   // Result shows one cycle after the pop
      chk_exp   <= cmd_exp;
   end

   always @(negedge i_clk) begin
      entry_t exp_now;

      exp_now = chk_valid ? chk_exp : EMPTY_ENTRY;
      assert (o_pop_data === exp_now) else begin
         $display("Mismatch: o_pop_data = %h, expected %h", o_pop_data, exp_now);
         $display("SIMULATION FAILED");
         $fatal(1, "Wrong pop result at %0t", $time);
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired");
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      int unsigned op;
      int unsigned push_share;

      i_arst_n    = 1'b0;
      i_push      = 1'b0;
      i_push_data = '0;
      i_pop       = 1'b0;
      void'($urandom(RAND_SEED));
      repeat (2) @(posedge i_clk);
      #1;
      i_arst_n = 1'b1;
      idle_cycles(2);

      // Empty tree
      pop_one();
      idle_cycles(2);

      // One entry in, one out, then empty again
      push_one(16'h0123);
      pop_one();
      idle_cycles(1);
      pop_one();
      idle_cycles(2);

      // Fill both levels in descending order and drain with pops in WB
      for (int i = 0; i < CAPACITY; i++) begin
         push_one(prio_t'(2000 - i * 50));
      end
      repeat (CAPACITY + 1) begin
         pop_one();
         idle_cycles(1);
      end
      idle_cycles(2);

      // Pop right after a pop and both strobes high are ignored
      push_one(16'h0300);
      push_one(16'h0100);
      push_one(16'h0200);
      pop_one();
      pop_one();
      drive_cycle(1'b1, {16'hbeef, 16'h0050}, 1'b1);
      pop_one();
      idle_cycles(1);
      pop_one();
      idle_cycles(1);
      pop_one();
      idle_cycles(2);

      // Random mix with filling phases alternating with draining phases
      for (int n = 0; n < RANDOM_CMDS; n++) begin
         push_share = ((n % 200) < 100) ? 6 : 3;
         op         = $urandom % 10;
         if (op < push_share && model_q.size() < CAPACITY) begin
            push_one(fresh_prio());
         end else if (op < 9) begin
            pop_one();
         end else begin
            drive_cycle(1'b1, {meta_seq, fresh_prio()}, 1'b1);
         end
      end
      repeat (CAPACITY + 1) begin
         pop_one();
         idle_cycles(1);
      end
      idle_cycles(3);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
src/pifo_pkg.sv
src/pifo_slot_select.sv
src/pifo_node.sv
src/pifo_level_ram.sv
src/pifo_tree_top.sv
verification/tb_pifo_tree.sv

// File: Makefile
# Verilator build and run for the PIFO tree testbench

VERILATOR ?= verilator
SIM_TOP   ?= tb_pifo_tree
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR SIM_TOP FLIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(SIM_TOP) \
		--Mdir $(BUILD_DIR) -o V$(SIM_TOP) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
